/* verilog.f */
+incdir+hw
hw/video_pkg.sv
hw/panel_pkg.sv
hw/vga_timing.sv
hw/lab_top.sv
hw/seg7_scan.sv
hw/vga_pmod_out.sv
hw/board_top.sv
tests/tb_board_top.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_board_top -f verilog.f -Mdir obj_dir -o tb_board_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_board_top)
status=$?
echo "$sim_out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$sim_out" | grep -q "^Everything OK$"; then
    exit 0
fi
exit 1

/* tests/tb_board_top.sv */
`timescale 1ns/1ps

`include "board_macros.svh"

module tb_board_top;

    localparam int     LINE_CLKS   = 2 * `H_TOTAL;
    localparam int     FRAME_CLKS  = LINE_CLKS * `V_TOTAL;
    localparam int     MAX_PRESSES = 300;
    localparam int     KEY_CLKS    = 2 * MAX_PRESSES * 16 + 1000;
    // Three frames of video tests, one frame of margin, then the key tests
    localparam longint WATCHDOG_NS = longint'(4 * FRAME_CLKS + KEY_CLKS) * 8;

    logic                  i_clk;
    logic                  i_rst_n;
    panel_pkg::key_t       i_key;
    panel_pkg::led_t       o_led;
    panel_pkg::digit_sel_t o_digit;
    panel_pkg::seg_t       o_hgfedcba;
    logic [7:0]            o_pmod_0;
    logic [7:0]            o_pmod_1;
    video_pkg::pmod_vga_u  pmod_word;

    integer seed = 55618;
    int     errors = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     count = 0;             // Expected press count

    board_top board_top_i
    (
        .i_clk      ( i_clk      ),
        .i_rst_n    ( i_rst_n    ),
        .i_key      ( i_key      ),
        .o_led      ( o_led      ),
        .o_digit    ( o_digit    ),
        .o_hgfedcba ( o_hgfedcba ),
        .o_pmod_0   ( o_pmod_0   ),
        .o_pmod_1   ( o_pmod_1   )
    );

    assign pmod_word = {o_pmod_1, o_pmod_0};

    always #4 i_clk = ~i_clk;      // 8 ns period

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the simulation ran longer than all tests should take");
        $display("Something failed");
        $finish;
    end

    //--------------------------------------------------------------------
    // Helpers

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before)
            $display("Test %s: passed", name);
        else
        begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, errors - errs_before);
        end
    endtask

    function automatic logic sync_level(input bit use_vsync);
        return use_vsync ? pmod_word.field.vsync : pmod_word.field.hsync;
    endfunction

    // Waits on negedges until a sync pin changes to the given level
    task automatic wait_sync(input bit use_vsync, input logic level, input int limit,
                             output int clocks);
        logic prev;
        logic cur;
        clocks = 0;
        prev = sync_level(use_vsync);
        while (clocks < limit)
        begin
            @(negedge i_clk);
            clocks++;
            cur = sync_level(use_vsync);
            if (cur == level && prev != level)
                return;
            prev = cur;
        end
        $display("Timeout: %s never went to %b within %0d clocks",
                 use_vsync ? "vsync" : "hsync", level, limit);
        errors++;
    endtask

    task automatic press_key0(input int n);
        int high_clks;
        int low_clks;
        @(posedge i_clk);
        #1;
        for (int i = 0; i < n; i++)
        begin
            high_clks = 4 + ($unsigned($random(seed)) % 5);  // Always above 3 clocks
            low_clks  = 4 + ($unsigned($random(seed)) % 5);
            i_key[0] = 1'b1;
            repeat (high_clks) @(posedge i_clk);
            #1 i_key[0] = 1'b0;
            repeat (low_clks) @(posedge i_clk);
            #1;
        end
    endtask

    // Standard gfedcba table, segment a in bit 0 and the point off
    function automatic logic [7:0] seg_pattern(input logic [3:0] nib);
        case (nib)
            4'h0: return 8'h3f;
            4'h1: return 8'h06;
            4'h2: return 8'h5b;
            4'h3: return 8'h4f;
            4'h4: return 8'h66;
            4'h5: return 8'h6d;
            4'h6: return 8'h7d;
            4'h7: return 8'h07;
            4'h8: return 8'h7f;
            4'h9: return 8'h6f;
            4'ha: return 8'h77;
            4'hb: return 8'h7c;
            4'hc: return 8'h39;
            4'hd: return 8'h5e;
            4'he: return 8'h79;
            default: return 8'h71;
        endcase
    endfunction

    //--------------------------------------------------------------------
    // Tests

    task automatic test_reset_state();
        int errs_before;
        errs_before = errors;
        @(negedge i_clk);
        if (pmod_word.field.hsync !== 1'b1 || pmod_word.field.vsync !== 1'b1)
        begin
            $display("[ERROR] %0t ns: syncs are %b%b after reset, expected 11", $time,
                     pmod_word.field.hsync, pmod_word.field.vsync);
            errors++;
        end
        if ({pmod_word.field.red, pmod_word.field.green, pmod_word.field.blue} !== 12'h000)
        begin
            $display("[ERROR] %0t ns: colour is not zero after reset", $time);
            errors++;
        end
        if (o_led !== 8'h00)
        begin
            $display("[ERROR] %0t ns: o_led is %h after reset, expected 00", $time, o_led);
            errors++;
        end
        if (o_digit !== panel_pkg::digit_sel_t'(1))
        begin
            $display("[ERROR] %0t ns: o_digit is %b after reset, expected digit 0",
                     $time, o_digit);
            errors++;
        end
        report_test("reset state", errs_before);
    endtask

    task automatic test_key_counter();
        int errs_before;
        errs_before = errors;
        count = 1 + ($unsigned($random(seed)) % MAX_PRESSES);
        press_key0(count);
        repeat (4) @(negedge i_clk);
        if (o_led !== 8'(count))
        begin
            $display("[ERROR] %0t ns: o_led is %0d, expected %0d", $time, o_led, 8'(count));
            errors++;
        end
        @(posedge i_clk);
        #1 i_key[1] = 1'b1;                // Clear
        repeat (6) @(posedge i_clk);
        #1 i_key[1] = 1'b0;
        repeat (4) @(negedge i_clk);
        if (o_led !== 8'h00)
        begin
            $display("[ERROR] %0t ns: o_led is %0d after clear, expected 0", $time, o_led);
            errors++;
        end
        count = 1 + ($unsigned($random(seed)) % MAX_PRESSES);
        press_key0(count);                 // Leaves a known count for later tests
        repeat (4) @(negedge i_clk);
        if (o_led !== 8'(count))
        begin
            $display("[ERROR] %0t ns: o_led is %0d, expected %0d", $time, o_led, 8'(count));
            errors++;
        end
        report_test("key counter", errs_before);
    endtask

    task automatic test_digit_scan();
        int                      errs_before;
        int                      idx;
        logic [3:0]              nib;
        logic [`N_DIGITS-1:0]    seen;
        errs_before = errors;
        seen = '0;
        for (int c = 0; c < `N_DIGITS * `SEG_SCAN_CYCLES; c++)
        begin
            @(negedge i_clk);
            if (!$onehot(o_digit))
            begin
                $display("[ERROR] %0t ns: o_digit %b is not one-hot", $time, o_digit);
                errors++;
            end
            else
            begin
                idx = 0;
                for (int d = 0; d < `N_DIGITS; d++)
                    if (o_digit[d])
                        idx = d;
                seen[idx] = 1'b1;
                nib = 4'(count >> (4 * idx));
                if (o_hgfedcba !== seg_pattern(nib))
                begin
                    $display("[ERROR] %0t ns: digit %0d shows %h, expected %h", $time,
                             idx, o_hgfedcba, seg_pattern(nib));
                    errors++;
                end
            end
        end
        if (seen !== '1)
        begin
            $display("[ERROR] %0t ns: only digits %b appeared in one scan", $time, seen);
            errors++;
        end
        report_test("digit scan", errs_before);
    endtask

    task automatic test_horizontal();
        int errs_before;
        int low_clks;
        int high_clks;
        errs_before = errors;
        wait_sync(1'b0, 1'b0, LINE_CLKS + 8, low_clks);
        for (int l = 0; l < 4; l++)
        begin
            wait_sync(1'b0, 1'b1, LINE_CLKS + 8, low_clks);
            wait_sync(1'b0, 1'b0, LINE_CLKS + 8, high_clks);
            if (low_clks != 2 * `H_SYNC)
            begin
                $display("[ERROR] %0t ns: hsync low for %0d clocks, expected %0d", $time,
                         low_clks, 2 * `H_SYNC);
                errors++;
            end
            if (low_clks + high_clks != LINE_CLKS)
            begin
                $display("[ERROR] %0t ns: line took %0d clocks, expected %0d", $time,
                         low_clks + high_clks, LINE_CLKS);
                errors++;
            end
        end
        report_test("horizontal timing", errs_before);
    endtask

    task automatic test_vertical();
        int errs_before;
        int low_clks;
        int high_clks;
        errs_before = errors;
        wait_sync(1'b1, 1'b0, FRAME_CLKS + 8, low_clks);
        wait_sync(1'b1, 1'b1, FRAME_CLKS + 8, low_clks);
        wait_sync(1'b1, 1'b0, FRAME_CLKS + 8, high_clks);
        if (low_clks != `V_SYNC * LINE_CLKS)
        begin
            $display("[ERROR] %0t ns: vsync low for %0d clocks, expected %0d", $time,
                     low_clks, `V_SYNC * LINE_CLKS);
            errors++;
        end
        if (low_clks + high_clks != FRAME_CLKS)
        begin
            $display("[ERROR] %0t ns: frame took %0d clocks, expected %0d", $time,
                     low_clks + high_clks, FRAME_CLKS);
            errors++;
        end
        report_test("vertical timing", errs_before);
    endtask

    task automatic test_pattern();
        int              errs_before;
        int              clocks;
        int              line;
        int              n;
        logic            active;
        video_pkg::rgb_t exp_rgb;
        errs_before = errors;
        wait_sync(1'b1, 1'b1, FRAME_CLKS + 8, clocks);
        // Hsync rise number V_BACK leads into visible line 0
        for (int c = 1; c <= `V_BACK + `V_ACTIVE + 2; c++)
        begin
            wait_sync(1'b0, 1'b1, LINE_CLKS + 8, clocks);
            line = c - `V_BACK;
            // Whole line, back porch through the end of sync
            for (int k = 0; k < `H_TOTAL; k++)
            begin
                if (k > 0)
                    repeat (2) @(negedge i_clk);   // One pixel is two clocks
                n = k - `H_BACK;
                active = line >= 0 && line < `V_ACTIVE && n >= 0 && n < `H_ACTIVE;
                exp_rgb.red   = active ? 4'(n >> 4) : 4'h0;
                exp_rgb.green = active ? 4'(line >> 4) : 4'h0;
                exp_rgb.blue  = active ? 4'(count) : 4'h0;
                if (pmod_word.field.red !== exp_rgb.red ||
                    pmod_word.field.green !== exp_rgb.green ||
                    pmod_word.field.blue !== exp_rgb.blue)
                begin
                    $display("[ERROR] %0t ns: line %0d pixel %0d rgb %h%h%h, expected %h",
                             $time, line, n, pmod_word.field.red, pmod_word.field.green,
                             pmod_word.field.blue, exp_rgb);
                    errors++;
                end
                if (pmod_word.field.pad !== 2'b00)
                begin
                    $display("[ERROR] %0t ns: unused PMOD pins are %b, expected 00", $time,
                             pmod_word.field.pad);
                    errors++;
                end
                if (errors > errs_before + 10)
                    break;
            end
            if (errors > errs_before + 10)
                break;                             // Enough to see the problem
        end
        report_test("pattern and blanking", errs_before);
    endtask

    //--------------------------------------------------------------------

    initial
    begin
        i_clk   = 1'b0;
        i_rst_n = 1'b0;
        i_key   = '0;
        repeat (16) @(posedge i_clk);
        #1 i_rst_n = 1'b1;

        test_reset_state();
        test_key_counter();
        test_digit_scan();
        test_horizontal();
        test_vertical();
        test_pattern();

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

/* hw/board_top.sv */
`timescale 1ns/1ps

module board_top
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  panel_pkg::key_t       i_key,
    output panel_pkg::led_t       o_led,
    output panel_pkg::digit_sel_t o_digit,
    output panel_pkg::seg_t       o_hgfedcba,
    output logic [7:0]            o_pmod_0,
    output logic [7:0]            o_pmod_1
);

    logic                   pix_stb;
    video_pkg::pixel_pos_t  pos;
    video_pkg::vga_sync_t   vga_sync;
    video_pkg::rgb_t        rgb;
    panel_pkg::hex_digits_t hex;
    video_pkg::pmod_vga_u   pmod;

    //------------------------------------------------------------------

    vga_timing vga_timing_i
    (
        .i_clk      ( i_clk      ),
        .i_rst_n    ( i_rst_n    ),
        .o_pix_stb  ( pix_stb    ),
        .o_pos      ( pos        ),
        .o_sync     ( vga_sync   )
    );

    lab_top lab_top_i
    (
        .i_clk      ( i_clk      ),
        .i_rst_n    ( i_rst_n    ),
        .i_key      ( i_key      ),
        .i_pix_stb  ( pix_stb    ),
        .i_pos      ( pos        ),
        .o_led      ( o_led      ),
        .o_hex      ( hex        ),
        .o_rgb      ( rgb        )
    );

    seg7_scan seg7_scan_i
    (
        .i_clk      ( i_clk      ),
        .i_rst_n    ( i_rst_n    ),
        .i_hex      ( hex        ),
        .o_digit    ( o_digit    ),
        .o_hgfedcba ( o_hgfedcba )
    );

    vga_pmod_out vga_pmod_out_i
    (
        .i_clk      ( i_clk      ),
        .i_rst_n    ( i_rst_n    ),
        .i_pix_stb  ( pix_stb    ),
        .i_sync     ( vga_sync   ),
        .i_rgb      ( rgb        ),
        .o_pmod     ( pmod       )
    );

    assign {o_pmod_1, o_pmod_0} = pmod.raw;  // Upper byte on PMOD_1

endmodule

/* hw/vga_pmod_out.sv */
`timescale 1ns/1ps

module vga_pmod_out
(
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_pix_stb,
    input  video_pkg::vga_sync_t i_sync,
    input  video_pkg::rgb_t      i_rgb,
    output video_pkg::pmod_vga_u o_pmod
);

    localparam logic [15:0] PMOD_IDLE = 16'h0003;  // Syncs high, colour off

    video_pkg::vga_sync_t sync_d;
    video_pkg::rgb_t      rgb_vis;
    video_pkg::pmod_vga_u pmod_next;

    // Colour arrives one pixel late, so sync waits one pixel too
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            sync_d.hsync      <= 1'b1;
            sync_d.vsync      <= 1'b1;
            sync_d.display_on <= 1'b0;
        end
        else if (i_pix_stb)
            sync_d <= i_sync;
    end

    assign rgb_vis = sync_d.display_on ? i_rgb : '0;  // Blank outside the picture

    always_comb
    begin
        pmod_next.field.red   = rgb_vis.red;
        pmod_next.field.blue  = rgb_vis.blue;
        pmod_next.field.green = rgb_vis.green;
        pmod_next.field.pad   = 2'b00;
        pmod_next.field.vsync = sync_d.vsync;
        pmod_next.field.hsync = sync_d.hsync;
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            o_pmod.raw <= PMOD_IDLE;
        else if (i_pix_stb)
            o_pmod <= pmod_next;
    end

    a_blank: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_pix_stb && !sync_d.display_on |=>
            o_pmod.field.red == '0 && o_pmod.field.green == '0 &&
            o_pmod.field.blue == '0);

endmodule

/* hw/seg7_scan.sv */
`timescale 1ns/1ps

`include "board_macros.svh"

module seg7_scan
(
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  panel_pkg::hex_digits_t i_hex,
    output panel_pkg::digit_sel_t  o_digit,
    output panel_pkg::seg_t        o_hgfedcba
);

    localparam int SCAN_W  = $clog2(`SEG_SCAN_CYCLES);
    localparam int INDEX_W = $clog2(`N_DIGITS);

    logic [SCAN_W-1:0]  scan_cnt;
    logic [INDEX_W-1:0] digit_idx;
    logic [3:0]         nibble;
    panel_pkg::seg_t    abcdefgh;

    // Refresh and digit rotation
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            scan_cnt  <= '0;
            digit_idx <= '0;
            o_digit   <= panel_pkg::digit_sel_t'(1);
        end
        else if (scan_cnt == `SEG_SCAN_CYCLES - 1)
        begin
            scan_cnt  <= '0;
            o_digit   <= {o_digit[`N_DIGITS-2:0], o_digit[`N_DIGITS-1]};
            digit_idx <= (digit_idx == `N_DIGITS - 1) ? '0 : digit_idx + 1'b1;
        end
        else
            scan_cnt <= scan_cnt + 1'b1;
    end

    assign nibble = i_hex[digit_idx];

    //------------------------------------------------------------------
    // Hex decode, point always off

    always_comb
    begin
        case (nibble)
            4'h0: abcdefgh = 8'b1111_1100;
            4'h1: abcdefgh = 8'b0110_0000;
            4'h2: abcdefgh = 8'b1101_1010;
            4'h3: abcdefgh = 8'b1111_0010;
            4'h4: abcdefgh = 8'b0110_0110;
            4'h5: abcdefgh = 8'b1011_0110;
            4'h6: abcdefgh = 8'b1011_1110;
            4'h7: abcdefgh = 8'b1110_0000;
            4'h8: abcdefgh = 8'b1111_1110;
            4'h9: abcdefgh = 8'b1111_0110;
            4'ha: abcdefgh = 8'b1110_1110;
            4'hb: abcdefgh = 8'b0011_1110;
            4'hc: abcdefgh = 8'b1001_1100;
            4'hd: abcdefgh = 8'b0111_1010;
            4'he: abcdefgh = 8'b1001_1110;
            default: abcdefgh = 8'b1000_1110;   // F
        endcase
    end

    // Board wires segment a to bit 0
    always_comb
    begin
        for (int i = 0; i < $bits(abcdefgh); i++)
            o_hgfedcba[i] = abcdefgh[$bits(abcdefgh) - 1 - i];
    end

    a_digit_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $onehot(o_digit) && o_digit[digit_idx]);

endmodule

/* hw/lab_top.sv */
`timescale 1ns/1ps

module lab_top
(
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  panel_pkg::key_t        i_key,
    input  logic                   i_pix_stb,
    input  video_pkg::pixel_pos_t  i_pos,
    output panel_pkg::led_t        o_led,
    output panel_pkg::hex_digits_t o_hex,
    output video_pkg::rgb_t        o_rgb
);

    panel_pkg::key_t key_meta;
    panel_pkg::key_t key_sync;
    logic            key0_prev;
    logic            press;
    logic [15:0]     press_cnt;

    //------------------------------------------------------------------
    // Keys

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            key_meta  <= '0;
            key_sync  <= '0;
            key0_prev <= 1'b0;
        end
        else
        begin
            key_meta  <= i_key;
            key_sync  <= key_meta;
            key0_prev <= key_sync[0];
        end
    end

    assign press = key_sync[0] && !key0_prev;  // Rising edge of key 0

    // Count moves on the third edge after the key rises
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            press_cnt <= '0;
        else if (key_sync[1])
            press_cnt <= '0;                    // Clear wins over a press
        else if (press)
            press_cnt <= press_cnt + 16'd1;
    end

    assign o_led = press_cnt[7:0];
    assign o_hex = press_cnt;                   // Digit 0 is the low nibble

    //------------------------------------------------------------------
    // Test pattern, one pixel behind the position

    always_ff @(posedge i_clk)
    begin
        if (i_pix_stb)
        begin
            o_rgb.red   <= i_pos.x[7:4];
            o_rgb.green <= i_pos.y[7:4];
            o_rgb.blue  <= press_cnt[3:0];
        end
    end

endmodule

/* hw/vga_timing.sv */
`timescale 1ns/1ps

`include "board_macros.svh"

module vga_timing
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    output logic                  o_pix_stb,
    output video_pkg::pixel_pos_t o_pos,
    output video_pkg::vga_sync_t  o_sync
);

    localparam int DIV        = `CLK_MHZ / `PIXEL_MHZ;
    localparam int H_SYNC_BEG = `H_ACTIVE + `H_FRONT;
    localparam int H_SYNC_END = H_SYNC_BEG + `H_SYNC;
    localparam int V_SYNC_BEG = `V_ACTIVE + `V_FRONT;
    localparam int V_SYNC_END = V_SYNC_BEG + `V_SYNC;

    logic [$clog2(DIV)-1:0] div_cnt;
    logic [9:0]             x_next;
    logic [9:0]             y_next;

    //------------------------------------------------------------------
    // Pixel enable, one clock in DIV

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            div_cnt   <= '0;
            o_pix_stb <= 1'b0;
        end
        else if (div_cnt == DIV - 1)
        begin
            div_cnt   <= '0;
            o_pix_stb <= 1'b1;
        end
        else
        begin
            div_cnt   <= div_cnt + 1'b1;
            o_pix_stb <= 1'b0;
        end
    end

    //------------------------------------------------------------------
    // Counters, with sync decoded from the next position so both line up

    always_comb
    begin
        x_next = o_pos.x + 10'd1;
        y_next = o_pos.y;
        if (o_pos.x == `H_TOTAL - 1)
        begin
            x_next = '0;
            y_next = (o_pos.y == `V_TOTAL - 1) ? '0 : o_pos.y + 10'd1;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_pos             <= '0;
            o_sync.hsync      <= 1'b1;
            o_sync.vsync      <= 1'b1;
            o_sync.display_on <= 1'b0;
        end
        else if (o_pix_stb)
        begin
            o_pos.x           <= x_next;
            o_pos.y           <= y_next;
            o_sync.hsync      <= !(x_next >= H_SYNC_BEG && x_next < H_SYNC_END);
            o_sync.vsync      <= !(y_next >= V_SYNC_BEG && y_next < V_SYNC_END);
            o_sync.display_on <= (x_next < `H_ACTIVE) && (y_next < `V_ACTIVE);
        end
    end

    a_pos_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_pos.x < `H_TOTAL && o_pos.y < `V_TOTAL);

endmodule

/* hw/panel_pkg.sv */
`include "board_macros.svh"

package panel_pkg;

    // Push buttons, bit 0 counts and bit 1 clears
    typedef logic [1:0] key_t;

    typedef logic [7:0] led_t;

    // One-hot, active high
    typedef logic [`N_DIGITS-1:0] digit_sel_t;

    // Segments a..g then the point
    typedef logic [7:0] seg_t;

    // Nibble 0 is the least significant digit
    typedef logic [`N_DIGITS-1:0][3:0] hex_digits_t;

endpackage

/* hw/video_pkg.sv */
package video_pkg;

    // Screen position, x on top
    typedef struct packed
    {
        logic [9:0] x;
        logic [9:0] y;
    } pixel_pos_t;

    typedef struct packed
    {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    typedef struct packed
    {
        logic hsync;       // Active low
        logic vsync;       // Active low
        logic display_on;
    } vga_sync_t;

    // Pin order on the two PMOD bytes
    typedef struct packed
    {
        logic [3:0] red;   // PMOD_1 upper nibble
        logic [3:0] blue;
        logic [3:0] green; // PMOD_0 upper nibble
        logic [1:0] pad;   // Unused pins, held low
        logic       vsync;
        logic       hsync;
    } pmod_vga_fields_t;

    typedef union packed
    {
        logic [15:0]      raw;
        pmod_vga_fields_t field;
    } pmod_vga_u;

endpackage

/* hw/board_macros.svh */
`ifndef BOARD_MACROS_SVH
`define BOARD_MACROS_SVH

// Clocks
`define CLK_MHZ          50
`define PIXEL_MHZ        25

//----------------------------------------------------------------------
// 640x480 at 60 Hz

`define H_ACTIVE         640
`define H_FRONT          16
`define H_SYNC           96
`define H_BACK           48
`define H_TOTAL          (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

`define V_ACTIVE         480
`define V_FRONT          10
`define V_SYNC           2
`define V_BACK           33
`define V_TOTAL          (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

//----------------------------------------------------------------------
// Front panel

`define N_DIGITS         4
`define SEG_SCAN_CYCLES  64     // Clocks each digit stays lit

`endif
